// File: maze_pkg.sv
/*
 * maze geometry, APB register map, reset colours and the border maze rows
 */
package maze_pkg;

	// tile and maze geometry
	localparam int tile_px = 4;
	localparam int sub_w = $clog2(tile_px);
	localparam int map_cols = 29;
	localparam int map_rows = 13;
	localparam int col_w = 5;
	localparam int row_w = 4;
	localparam int x_w = 8;
	localparam int y_w = 7;
	localparam int frame_width = map_cols * tile_px;
	localparam int frame_height = map_rows * tile_px;

	// RGB332
	localparam int colour_w = 8;

	localparam int addr_w = 8;
	localparam int data_w = 32;
	localparam int frames_w = 16;

	// register offsets
	localparam logic [addr_w-1:0] reg_ctrl = 8'h00;
	localparam logic [addr_w-1:0] reg_wall = 8'h04;
	localparam logic [addr_w-1:0] reg_floor = 8'h08;
	localparam logic [addr_w-1:0] reg_player = 8'h0C;
	localparam logic [addr_w-1:0] reg_frames = 8'h10;
	localparam logic [addr_w-1:0] reg_player_colour = 8'h14;
	localparam logic [addr_w-1:0] reg_map_base = 8'h40;
	localparam logic [addr_w-1:0] reg_map_last = addr_w'(8'h40 + 4 * (map_rows - 1));

	// player register, row field starts at bit 8
	localparam int player_row_lsb = 8;

	// reset values
	localparam logic [colour_w-1:0] wall_reset = 8'hFF;
	localparam logic [colour_w-1:0] floor_reset = 8'h00;
	localparam logic [colour_w-1:0] player_colour_reset = 8'hE0;
	localparam logic [col_w-1:0] player_col_reset = 5'd1;
	localparam logic [row_w-1:0] player_row_reset = 4'd1;

	// border maze, full wall on top and bottom, side walls elsewhere
	localparam logic [map_cols-1:0] border_row = '1;
	localparam logic [map_cols-1:0] side_row = {1'b1, {(map_cols - 2){1'b0}}, 1'b1};

endpackage

// File: maze_regs.sv
/*
 * APB register block: control, colours, player tile, frame counter,
 * and the forwarding of map row accesses
 */
`timescale 1ns/1ps

module maze_regs (
	input  logic                              clock,
	input  logic                              resetn,
	input  logic                              psel,
	input  logic                              penable,
	input  logic                              pwrite,
	input  logic [maze_pkg::addr_w-1:0]       paddr,
	input  logic [maze_pkg::data_w-1:0]       pwdata,
	output logic [maze_pkg::data_w-1:0]       prdata,
	output logic                              pready,
	output logic                              pslverr,
	input  logic                              busy,
	input  logic                              frame_done,
	output logic                              start,
	output logic [maze_pkg::colour_w-1:0]     wall_colour,
	output logic [maze_pkg::colour_w-1:0]     floor_colour,
	output logic [maze_pkg::colour_w-1:0]     player_colour,
	output logic [maze_pkg::col_w-1:0]        player_col,
	output logic [maze_pkg::row_w-1:0]        player_row,
	output logic                              map_we,
	output logic [maze_pkg::row_w-1:0]        map_row,
	output logic [maze_pkg::map_cols-1:0]     map_wdata,
	input  logic [maze_pkg::map_cols-1:0]     map_rdata
);
	import maze_pkg::*;

	logic access;
	logic is_map;
	logic addr_ok;
	logic wr_ok;
	logic [frames_w-1:0] frames;

	assign access = psel & penable;
	assign is_map = (paddr >= reg_map_base) && (paddr <= reg_map_last) && (paddr[1:0] == 2'b00);

	always_comb begin
		case (paddr)
			reg_ctrl, reg_wall, reg_floor, reg_player,
			reg_frames, reg_player_colour: addr_ok = 1'b1;
			default: addr_ok = is_map;
		endcase
	end

	// frame counter is read only
	assign pready = 1'b1;
	assign pslverr = access & (~addr_ok | (pwrite & (paddr == reg_frames)));
	assign wr_ok = access & pwrite & ~pslverr;

	// start is combinational so the scanner begins the next cycle
	assign start = wr_ok & (paddr == reg_ctrl) & pwdata[0];

	assign map_row = row_w'((paddr - reg_map_base) >> 2);
	assign map_we = wr_ok & is_map;
	assign map_wdata = pwdata[map_cols-1:0];

	always_ff @(posedge clock) begin
		if (!resetn) begin
			wall_colour <= wall_reset;
			floor_colour <= floor_reset;
			player_colour <= player_colour_reset;
			player_col <= player_col_reset;
			player_row <= player_row_reset;
		end else if (wr_ok) begin
			case (paddr)
				reg_wall: wall_colour <= pwdata[colour_w-1:0];
				reg_floor: floor_colour <= pwdata[colour_w-1:0];
				reg_player_colour: player_colour <= pwdata[colour_w-1:0];
				reg_player: begin
					player_col <= pwdata[col_w-1:0];
					player_row <= pwdata[player_row_lsb +: row_w];
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (!resetn)
			frames <= '0;
		else if (frame_done)
			frames <= frames + 1'b1;
	end

	always_comb begin
		prdata = '0;
		case (paddr)
			reg_ctrl: prdata[1] = busy;
			reg_wall: prdata[colour_w-1:0] = wall_colour;
			reg_floor: prdata[colour_w-1:0] = floor_colour;
			reg_player_colour: prdata[colour_w-1:0] = player_colour;
			reg_frames: prdata[frames_w-1:0] = frames;
			reg_player: begin
				prdata[col_w-1:0] = player_col;
				prdata[player_row_lsb +: row_w] = player_row;
			end
			default: begin
				if (is_map)
					prdata[map_cols-1:0] = map_rdata;
			end
		endcase
	end

	// APB3 access phase always follows a setup phase
	penable_needs_psel: assert property (@(posedge clock) disable iff (!resetn)
		penable |-> psel);

endmodule

// File: maze_map.sv
/*
 * maze tile memory, one wall bit per tile
 * APB row port and registered lookup for the scanner
 */
`timescale 1ns/1ps

module maze_map (
	input  logic                          clock,
	input  logic                          resetn,
	input  logic                          map_we,
	input  logic [maze_pkg::row_w-1:0]    map_row,
	input  logic [maze_pkg::map_cols-1:0] map_wdata,
	output logic [maze_pkg::map_cols-1:0] map_rdata,
	input  logic                          scan_valid,
	input  logic [maze_pkg::col_w-1:0]    scan_col,
	input  logic [maze_pkg::row_w-1:0]    scan_row,
	output logic                          tile_wall
);
	import maze_pkg::*;

	logic [map_cols-1:0] rows [map_rows];

	// reset loads the border maze
	always_ff @(posedge clock) begin
		if (!resetn) begin
			for (int r = 0; r < map_rows; r++) begin
				if (r == 0 || r == map_rows - 1)
					rows[r] <= border_row;
				else
					rows[r] <= side_row;
			end
		end else if (map_we) begin
			rows[map_row] <= map_wdata;
		end
	end

	assign map_rdata = (map_row < row_w'(map_rows)) ? rows[map_row] : '0;

	// one cycle lookup latency, shader lines up with this
	always_ff @(posedge clock) begin
		if (scan_valid)
			tile_wall <= rows[scan_row][scan_col];
	end

	// register block only strobes rows that exist
	map_row_in_range: assert property (@(posedge clock) disable iff (!resetn)
		map_we |-> (map_row < row_w'(map_rows)));

endmodule

// File: maze_scan.sv
/*
 * frame walker, one pixel per cycle in raster order
 * nested sub-tile x, tile column, sub-tile y and tile row counters
 */
`timescale 1ns/1ps

module maze_scan (
	input  logic                       clock,
	input  logic                       resetn,
	input  logic                       start,
	output logic                       busy,
	output logic                       scan_valid,
	output logic [maze_pkg::col_w-1:0] scan_col,
	output logic [maze_pkg::row_w-1:0] scan_row,
	output logic [maze_pkg::x_w-1:0]   scan_x,
	output logic [maze_pkg::y_w-1:0]   scan_y,
	output logic                       scan_last
);
	import maze_pkg::*;

	logic [sub_w-1:0] sub_x;
	logic [sub_w-1:0] sub_y;
	logic x_end;
	logic col_end;
	logic y_end;
	logic row_end;

	assign x_end = (sub_x == sub_w'(tile_px - 1));
	assign col_end = (scan_col == col_w'(map_cols - 1));
	assign y_end = (sub_y == sub_w'(tile_px - 1));
	assign row_end = (scan_row == row_w'(map_rows - 1));

	assign scan_valid = busy;
	assign scan_last = busy & x_end & col_end & y_end & row_end;

	// pixel coordinate is tile index times tile size plus offset
	assign scan_x = x_w'(scan_col) * x_w'(tile_px) + x_w'(sub_x);
	assign scan_y = y_w'(scan_row) * y_w'(tile_px) + y_w'(sub_y);

	always_ff @(posedge clock) begin
		if (!resetn) begin
			busy <= 1'b0;
			sub_x <= '0;
			scan_col <= '0;
			sub_y <= '0;
			scan_row <= '0;
		end else if (!busy) begin
			// start while busy never reaches here
			if (start)
				busy <= 1'b1;
		end else begin
			if (scan_last)
				busy <= 1'b0;
			if (!x_end) begin
				sub_x <= sub_x + 1'b1;
			end else begin
				sub_x <= '0;
				if (!col_end) begin
					scan_col <= scan_col + 1'b1;
				end else begin
					scan_col <= '0;
					if (!y_end) begin
						sub_y <= sub_y + 1'b1;
					end else begin
						sub_y <= '0;
						// all counters wrap to zero after the last pixel
						if (!row_end)
							scan_row <= scan_row + 1'b1;
						else
							scan_row <= '0;
					end
				end
			end
		end
	end

	scan_in_frame: assert property (@(posedge clock) disable iff (!resetn)
		scan_valid |-> (scan_x < x_w'(frame_width)) && (scan_y < y_w'(frame_height)));

endmodule

// File: maze_shade.sv
/*
 * two stage shader from scanned pixel and tile bit to plot write
 */
`timescale 1ns/1ps

module maze_shade (
	input  logic                          clock,
	input  logic                          resetn,
	input  logic                          scan_valid,
	input  logic [maze_pkg::col_w-1:0]    scan_col,
	input  logic [maze_pkg::row_w-1:0]    scan_row,
	input  logic [maze_pkg::x_w-1:0]      scan_x,
	input  logic [maze_pkg::y_w-1:0]      scan_y,
	input  logic                          scan_last,
	input  logic                          tile_wall,
	input  logic [maze_pkg::colour_w-1:0] wall_colour,
	input  logic [maze_pkg::colour_w-1:0] floor_colour,
	input  logic [maze_pkg::colour_w-1:0] player_colour,
	input  logic [maze_pkg::col_w-1:0]    player_col,
	input  logic [maze_pkg::row_w-1:0]    player_row,
	output logic [maze_pkg::x_w-1:0]      vga_x,
	output logic [maze_pkg::y_w-1:0]      vga_y,
	output logic [maze_pkg::colour_w-1:0] colour,
	output logic                          plot,
	output logic                          frame_done
);
	import maze_pkg::*;

	logic d_valid;
	logic d_last;
	logic d_player;
	logic [x_w-1:0] d_x;
	logic [y_w-1:0] d_y;

	// stage one, wait for the registered tile bit
	always_ff @(posedge clock) begin
		if (!resetn)
			d_valid <= 1'b0;
		else
			d_valid <= scan_valid;
	end

	always_ff @(posedge clock) begin
		d_x <= scan_x;
		d_y <= scan_y;
		d_last <= scan_last;
		d_player <= (scan_col == player_col) && (scan_row == player_row);
	end

	// stage two, pick colour and register the write
	always_ff @(posedge clock) begin
		if (!resetn) begin
			plot <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			plot <= d_valid;
			frame_done <= d_valid & d_last;
		end
	end

	always_ff @(posedge clock) begin
		vga_x <= d_x;
		vga_y <= d_y;
		if (d_player)
			colour <= player_colour;
		else if (tile_wall)
			colour <= wall_colour;
		else
			colour <= floor_colour;
	end

	// last flag stays aligned with the final pixel
	frame_done_with_plot: assert property (@(posedge clock) disable iff (!resetn)
		frame_done |-> plot && (vga_x == x_w'(frame_width - 1))
			&& (vga_y == y_w'(frame_height - 1)));

endmodule

// File: maze_draw_top.sv
/*
 * maze drawing subsystem: registers, tile map, scanner and shader
 */
`timescale 1ns/1ps

module maze_draw_top (
	input  logic                          clock,
	input  logic                          resetn,
	input  logic                          psel,
	input  logic                          penable,
	input  logic                          pwrite,
	input  logic [maze_pkg::addr_w-1:0]   paddr,
	input  logic [maze_pkg::data_w-1:0]   pwdata,
	output logic [maze_pkg::data_w-1:0]   prdata,
	output logic                          pready,
	output logic                          pslverr,
	output logic [maze_pkg::x_w-1:0]      vga_x,
	output logic [maze_pkg::y_w-1:0]      vga_y,
	output logic [maze_pkg::colour_w-1:0] colour,
	output logic                          plot,
	output logic                          frame_done
);
	import maze_pkg::*;

	logic start;
	logic busy;
	logic [colour_w-1:0] wall_colour;
	logic [colour_w-1:0] floor_colour;
	logic [colour_w-1:0] player_colour;
	logic [col_w-1:0] player_col;
	logic [row_w-1:0] player_row;
	logic map_we;
	logic [row_w-1:0] map_row;
	logic [map_cols-1:0] map_wdata;
	logic [map_cols-1:0] map_rdata;
	logic scan_valid;
	logic [col_w-1:0] scan_col;
	logic [row_w-1:0] scan_row;
	logic [x_w-1:0] scan_x;
	logic [y_w-1:0] scan_y;
	logic scan_last;
	logic tile_wall;

	maze_regs u_regs (
		.clock(clock), .resetn(resetn),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.busy(busy), .frame_done(frame_done), .start(start),
		.wall_colour(wall_colour), .floor_colour(floor_colour),
		.player_colour(player_colour), .player_col(player_col), .player_row(player_row),
		.map_we(map_we), .map_row(map_row), .map_wdata(map_wdata), .map_rdata(map_rdata)
	);

	maze_map u_map (
		.clock(clock), .resetn(resetn),
		.map_we(map_we), .map_row(map_row), .map_wdata(map_wdata), .map_rdata(map_rdata),
		.scan_valid(scan_valid), .scan_col(scan_col), .scan_row(scan_row),
		.tile_wall(tile_wall)
	);

	maze_scan u_scan (
		.clock(clock), .resetn(resetn), .start(start), .busy(busy),
		.scan_valid(scan_valid), .scan_col(scan_col), .scan_row(scan_row),
		.scan_x(scan_x), .scan_y(scan_y), .scan_last(scan_last)
	);

	maze_shade u_shade (
		.clock(clock), .resetn(resetn),
		.scan_valid(scan_valid), .scan_col(scan_col), .scan_row(scan_row),
		.scan_x(scan_x), .scan_y(scan_y), .scan_last(scan_last), .tile_wall(tile_wall),
		.wall_colour(wall_colour), .floor_colour(floor_colour),
		.player_colour(player_colour), .player_col(player_col), .player_row(player_row),
		.vga_x(vga_x), .vga_y(vga_y), .colour(colour), .plot(plot), .frame_done(frame_done)
	);

endmodule

// File: tb_maze_draw.sv
/*
 * directed testbench for the maze drawing subsystem
 * APB driver, plot monitor, reference maze model and compare tasks
 */
`timescale 1ns/1ps

module tb_maze_draw;
	import maze_pkg::*;

	localparam int frame_pixels = map_cols * map_rows * tile_px * tile_px;
	localparam int frame_timeout = 8000;
	localparam int start_latency = 3;

	logic clock;
	logic resetn;
	logic psel;
	logic penable;
	logic pwrite;
	logic [addr_w-1:0] paddr;
	logic [data_w-1:0] pwdata;
	logic [data_w-1:0] prdata;
	logic pready;
	logic pslverr;
	logic [x_w-1:0] vga_x;
	logic [y_w-1:0] vga_y;
	logic [colour_w-1:0] colour;
	logic plot;
	logic frame_done;

	// reference model of map and registers
	logic [map_cols-1:0] model_map [map_rows];
	logic [colour_w-1:0] model_wall;
	logic [colour_w-1:0] model_floor;
	logic [colour_w-1:0] model_player_colour;
	logic [col_w-1:0] model_col;
	logic [row_w-1:0] model_row;
	int model_frames;

	// plot writes of the current frame
	logic [x_w-1:0] got_x [$];
	logic [y_w-1:0] got_y [$];
	logic [colour_w-1:0] got_c [$];
	int done_at [$];
	int cycle;
	int first_cycle;
	int last_cycle;
	int access_cycle;
	int start_cycle;

	logic [15:0] lfsr;
	int checks;
	int errors;

	maze_draw_top DUT (
		.clock(clock), .resetn(resetn),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.vga_x(vga_x), .vga_y(vga_y), .colour(colour), .plot(plot), .frame_done(frame_done)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// outputs are registered, so the falling edge sees them settled
	always @(negedge clock) begin
		cycle++;
		if (plot) begin
			if (got_x.size() == 0)
				first_cycle = cycle;
			last_cycle = cycle;
			got_x.push_back(vga_x);
			got_y.push_back(vga_y);
			got_c.push_back(colour);
			if (frame_done)
				done_at.push_back(got_x.size() - 1);
		end else if (frame_done) begin
			errors++;
			$display("ERROR %0t: frame_done pulsed without a plot write", $time);
		end
	end

	// galois form, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic random_word(output logic [data_w-1:0] w);
		w = '0;
		for (int i = 0; i < data_w; i++) begin
			w[i] = lfsr[0];
			lfsr = lfsr_step(lfsr);
		end
	endtask

	task automatic check_word(input logic [data_w-1:0] got, input logic [data_w-1:0] exp,
		input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_pixel(input int idx, input logic [x_w-1:0] gx, input logic [y_w-1:0] gy,
		input logic [colour_w-1:0] gc, input logic [x_w-1:0] ex, input logic [y_w-1:0] ey,
		input logic [colour_w-1:0] ec);
		checks++;
		if (gx !== ex || gy !== ey || gc !== ec) begin
			errors++;
			$display("ERROR %0t: plot %0d at (%0d,%0d) colour %h, expected (%0d,%0d) colour %h",
				$time, idx, gx, gy, gc, ex, ey, ec);
		end
	endtask

	// setup phase, access phase, then back to idle
	task automatic apb_access(input logic wr, input logic [addr_w-1:0] addr,
		input logic [data_w-1:0] data, output logic [data_w-1:0] rdata, output logic err);
		@(negedge clock);
		psel = 1'b1;
		pwrite = wr;
		paddr = addr;
		pwdata = data;
		@(negedge clock);
		penable = 1'b1;
		#5;
		access_cycle = cycle;
		rdata = prdata;
		err = pslverr;
		check_flag(pready, 1'b1, "pready");
		@(negedge clock);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
		input logic exp_err);
		logic [data_w-1:0] rd;
		logic err;
		apb_access(1'b1, addr, data, rd, err);
		check_flag(err, exp_err, "pslverr on write");
	endtask

	task automatic apb_read(input logic [addr_w-1:0] addr, output logic [data_w-1:0] data,
		input logic exp_err);
		logic err;
		apb_access(1'b0, addr, '0, data, err);
		check_flag(err, exp_err, "pslverr on read");
	endtask

	task automatic read_check(input logic [addr_w-1:0] addr, input logic [data_w-1:0] exp,
		input string what);
		logic [data_w-1:0] rd;
		apb_read(addr, rd, 1'b0);
		check_word(rd, exp, what);
	endtask

	// player tile first, then wall bit, then floor
	function automatic logic [colour_w-1:0] expect_colour(input int tc, input int tr);
		if (tc == model_col && tr == model_row)
			return model_player_colour;
		if (model_map[tr][tc])
			return model_wall;
		return model_floor;
	endfunction

	task automatic start_frame();
		got_x.delete();
		got_y.delete();
		got_c.delete();
		done_at.delete();
		apb_write(reg_ctrl, 32'h1, 1'b0);
		start_cycle = access_cycle;
	endtask

	task automatic finish_frame();
		int waited;
		int idx;
		logic [data_w-1:0] rd;
		waited = 0;
		while (done_at.size() == 0 && waited < frame_timeout) begin
			@(negedge clock);
			waited++;
		end
		if (done_at.size() == 0) begin
			$display("timeout: no frame_done within %0d cycles", frame_timeout);
			$display("Verification failed");
			$finish;
		end
		// a few idle cycles to catch stray plots
		repeat (8) @(negedge clock);
		checks++;
		if (got_x.size() != frame_pixels || done_at.size() != 1 || done_at[0] != frame_pixels - 1
			|| last_cycle - first_cycle != frame_pixels - 1) begin
			errors++;
			$display("ERROR %0t: frame had %0d plots over %0d cycles, %0d frame_done pulses, expected %0d",
				$time, got_x.size(), last_cycle - first_cycle + 1, done_at.size(), frame_pixels);
		end
		checks++;
		if (first_cycle - start_cycle != start_latency) begin
			errors++;
			$display("ERROR %0t: first plot %0d cycles after start, expected %0d",
				$time, first_cycle - start_cycle, start_latency);
		end
		idx = 0;
		for (int tr = 0; tr < map_rows; tr++)
			for (int sy = 0; sy < tile_px; sy++)
				for (int tc = 0; tc < map_cols; tc++)
					for (int sx = 0; sx < tile_px; sx++) begin
						if (idx < got_x.size())
							check_pixel(idx, got_x[idx], got_y[idx], got_c[idx],
								x_w'(tc * tile_px + sx), y_w'(tr * tile_px + sy),
								expect_colour(tc, tr));
						idx++;
					end
		model_frames++;
		read_check(reg_frames, data_w'(model_frames), "frame counter");
		apb_read(reg_ctrl, rd, 1'b0);
		check_flag(rd[1], 1'b0, "busy after frame");
	endtask

	task automatic test_summary(input string name, input int errors_before);
		$display("test %s: %s", name, (errors == errors_before) ? "ok" : "FAILED");
	endtask

	initial begin
		int e0;
		logic [data_w-1:0] w;
		logic [data_w-1:0] rd;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		resetn = 1'b0;
		lfsr = 16'd35481;
		checks = 0;
		errors = 0;
		model_frames = 0;
		model_wall = 8'hFF;
		model_floor = 8'h00;
		model_player_colour = 8'hE0;
		model_col = 5'd1;
		model_row = 4'd1;
		// border maze
		for (int r = 0; r < map_rows; r++)
			model_map[r] = (r == 0 || r == map_rows - 1) ? {map_cols{1'b1}}
				: {1'b1, {(map_cols - 2){1'b0}}, 1'b1};
		repeat (5) @(negedge clock);
		resetn = 1'b1;

		e0 = errors;
		check_flag(plot, 1'b0, "plot after reset");
		read_check(reg_ctrl, 32'h0, "ctrl");
		read_check(reg_wall, 32'hFF, "wall colour");
		read_check(reg_floor, 32'h00, "floor colour");
		read_check(reg_player, 32'h0101, "player tile");
		read_check(reg_frames, 32'h0, "frame counter");
		read_check(reg_player_colour, 32'hE0, "player colour");
		for (int r = 0; r < map_rows; r++)
			read_check(addr_w'(reg_map_base + 4 * r), data_w'(model_map[r]), "map row");
		test_summary("reset values", e0);

		e0 = errors;
		apb_read(8'h18, rd, 1'b1);
		apb_write(8'h20, 32'h5, 1'b1);
		apb_read(8'h74, rd, 1'b1);
		apb_read(8'h42, rd, 1'b1);
		apb_write(reg_frames, 32'h7, 1'b1);
		read_check(reg_frames, 32'h0, "frame counter after refused write");
		apb_write(reg_floor, 32'h00, 1'b0);
		test_summary("bus errors", e0);

		e0 = errors;
		start_frame();
		finish_frame();
		test_summary("border frame", e0);

		e0 = errors;
		for (int r = 0; r < map_rows; r++) begin
			random_word(w);
			apb_write(addr_w'(reg_map_base + 4 * r), w, 1'b0);
			model_map[r] = w[map_cols-1:0];
		end
		for (int r = 0; r < map_rows; r++)
			read_check(addr_w'(reg_map_base + 4 * r), data_w'(model_map[r]), "map row");
		start_frame();
		finish_frame();
		test_summary("random map", e0);

		e0 = errors;
		apb_write(reg_wall, 32'h1C, 1'b0);
		model_wall = 8'h1C;
		apb_write(reg_floor, 32'h49, 1'b0);
		model_floor = 8'h49;
		apb_write(reg_player_colour, 32'hE3, 1'b0);
		model_player_colour = 8'hE3;
		apb_write(reg_player, 32'h0507, 1'b0);
		model_col = 5'd7;
		model_row = 4'd5;
		start_frame();
		repeat (300) @(negedge clock);
		// second start lands mid frame
		apb_write(reg_ctrl, 32'h1, 1'b0);
		apb_read(reg_ctrl, rd, 1'b0);
		check_flag(rd[1], 1'b1, "busy during frame");
		finish_frame();
		test_summary("colours, player and start while busy", e0);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// File: sim.f
maze_pkg.sv
maze_regs.sv
maze_map.sv
maze_scan.sv
maze_shade.sv
maze_draw_top.sv
tb_maze_draw.sv
